// ==== Makefile ====
# Verilator build and run for the sprite display testbench.
# Any variable can be overridden, e.g. make BUILD_DIR=build

VERILATOR       ?= verilator
TOP             ?= sprite_display_tb
FILE_LIST       ?= compile.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS        ?= +verilator+error+limit+100
PASS_TEXT       ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	@output="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
src/display_pkg.sv
src/sprite_pkg.sv
src/sprite_command_decoder.sv
src/sprite_engine.sv
src/frame_buffer.sv
src/sprite_display.sv
test/clock_gen.sv
test/sprite_display_sva.sv
test/sprite_display_tb.sv

// ==== src/display_pkg.sv ====
/*
 * Frame geometry and pixel write types shared by the sprite engine and
 * the frame buffer. Addresses are linear, x + y * frame width, and
 * 18 bits cover frames up to 262144 pixels.
 */

package display_pkg;

    typedef logic [9:0]  coordinate_t;     // Screen x or y.
    typedef logic [17:0] pixel_address_t;  // Linear frame buffer address.
    typedef logic [3:0]  color_index_t;    // Colour index, before palette lookup.

    // One frame buffer write. 23 bits.
    typedef struct packed {
        logic           write_enable;
        pixel_address_t address;
        color_index_t   color;
    } pixel_write_t;

endpackage

// ==== src/frame_buffer.sv ====
/*
 * Frame of FRAME_WIDTH x FRAME_HEIGHT colour indices.
 * Writes at or past the frame size are dropped. Reads return one cycle
 * after read_address, and out-of-frame reads return 0.
 * Contents start cleared, as block RAM initialisation.
 */

`timescale 1ns/10ps

module frame_buffer
    import display_pkg::*;
#(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 400
) (
    input  logic           clock_in,
    input  pixel_write_t   pixel_write,
    input  pixel_address_t read_address,
    output color_index_t   read_data
);

    localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;

    color_index_t memory [FRAME_PIXELS];
    logic         write_in_frame;
    logic         read_in_frame;

    assign write_in_frame = pixel_write.write_enable
                            && (int'(pixel_write.address) < FRAME_PIXELS);
    assign read_in_frame  = (int'(read_address) < FRAME_PIXELS);

    initial begin
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            memory[i] = '0;
        end
    end

    always_ff @(posedge clock_in) begin
        if (write_in_frame) begin
            memory[pixel_write.address] <= pixel_write.color;
        end
    end

    // Registered read port.
    always_ff @(posedge clock_in) begin
        if (read_in_frame) begin
            read_data <= memory[read_address];
        end else begin
            read_data <= '0;
        end
    end

endmodule

// ==== src/sprite_command_decoder.sv ====
/*
 * Parses the host byte stream into a sprite setup and paces the queued
 * pixel bytes to the engine. Each byte is held valid for 2P+2 cycles and
 * then low for 2, with P pixels per byte. BYTE_FIFO_DEPTH must be a power
 * of two. Bytes that find the queue full are lost and set overflow.
 * sprite_start always restarts the decoder, even mid-sprite.
 * sprite_end is only acted on once the header is complete.
 */

`timescale 1ns/10ps

module sprite_command_decoder
    import sprite_pkg::*;
#(
    parameter int BYTE_FIFO_DEPTH = 16
) (
    input  logic          clock_in,
    input  logic          reset,
    input  logic          sprite_start,
    input  logic          byte_valid,
    input  logic [7:0]    byte_data,
    input  logic          sprite_end,
    output sprite_setup_t setup,
    output logic          enable,
    output logic          pixel_valid,
    output logic [7:0]    pixel_byte,
    output logic          busy,
    output logic          overflow
);

    localparam int POINTER_WIDTH      = $clog2(BYTE_FIFO_DEPTH);
    localparam int COUNT_WIDTH        = $clog2(BYTE_FIFO_DEPTH + 1);
    localparam int HEADER_COUNT_WIDTH = $clog2(HEADER_BYTES);
    localparam int LOW_CYCLES         = 2;

    typedef enum logic [1:0] {
        PHASE_IDLE,
        PHASE_HEADER,
        PHASE_PIXELS
    } phase_t;

    phase_t                        phase;
    logic [HEADER_COUNT_WIDTH-1:0] header_count;
    logic                          end_seen;
    logic [7:0]                    fifo_memory [BYTE_FIFO_DEPTH];
    logic [POINTER_WIDTH-1:0]      write_pointer;
    logic [POINTER_WIDTH-1:0]      read_pointer;
    logic [COUNT_WIDTH-1:0]        fifo_count;
    logic                          fifo_full;
    logic                          fifo_empty;
    logic                          push;
    logic                          pop;
    logic [4:0]                    pace_count;
    logic                          sprite_done;

    assign enable     = (phase == PHASE_PIXELS);
    assign busy       = (phase != PHASE_IDLE);
    assign fifo_full  = (fifo_count == COUNT_WIDTH'(BYTE_FIFO_DEPTH));
    assign fifo_empty = (fifo_count == '0);

    assign push = enable && !end_seen && byte_valid && !fifo_full;
    assign pop  = enable && !pixel_valid && (pace_count == '0) && !fifo_empty;

    // Queue drained and the last low period over.
    assign sprite_done = enable && end_seen && fifo_empty && !pixel_valid
                         && (pace_count == '0);

    // ------------------------------
    // Header assembly
    // ------------------------------
    always_ff @(posedge clock_in) begin
        if (phase == PHASE_HEADER && byte_valid) begin
            case (int'(header_count))
                HEADER_X_HIGH: setup.x_position[9:8] <= byte_data[1:0];
                HEADER_X_LOW:  setup.x_position[7:0] <= byte_data;
                HEADER_Y_HIGH: setup.y_position[9:8] <= byte_data[1:0];
                HEADER_Y_LOW:  setup.y_position[7:0] <= byte_data;
                HEADER_W_HIGH: setup.width[9:8]      <= byte_data[1:0];
                HEADER_W_LOW:  setup.width[7:0]      <= byte_data;
                HEADER_MODE: begin
                    setup.palette_offset <= byte_data[7:4];
                    setup.color_mode     <= color_mode_t'(byte_data[1:0]);
                    setup.spare          <= 2'b00;
                end
                default: ;
            endcase
        end
    end

    // Queue storage and the byte handed to the engine.
    always_ff @(posedge clock_in) begin
        if (push) begin
            fifo_memory[write_pointer] <= byte_data;
        end
        if (pop) begin
            pixel_byte <= fifo_memory[read_pointer];
        end
    end

    // ------------------------------
    // Control, queue pointers, pacing
    // ------------------------------
    always_ff @(posedge clock_in) begin
        if (reset || sprite_start) begin
            phase         <= reset ? PHASE_IDLE : PHASE_HEADER;
            header_count  <= '0;
            end_seen      <= 1'b0;
            overflow      <= 1'b0;
            write_pointer <= '0;
            read_pointer  <= '0;
            fifo_count    <= '0;
            pixel_valid   <= 1'b0;
            pace_count    <= '0;
        end else begin
            if (phase == PHASE_HEADER && byte_valid) begin
                header_count <= header_count + 1'b1;
                if (int'(header_count) == HEADER_BYTES - 1) begin
                    phase <= PHASE_PIXELS;  // Enable rises next cycle.
                end
            end

            if (enable && sprite_end) begin
                end_seen <= 1'b1;
            end

            if (enable && !end_seen && byte_valid && fifo_full) begin
                overflow <= 1'b1;  // Held until the next sprite_start.
            end

            if (push) write_pointer <= write_pointer + 1'b1;
            if (pop) read_pointer <= read_pointer + 1'b1;

            if (push && !pop) begin
                fifo_count <= fifo_count + 1'b1;
            end else if (pop && !push) begin
                fifo_count <= fifo_count - 1'b1;
            end

            // Valid high for 2P+2 cycles, then low for LOW_CYCLES.
            if (pop) begin
                pixel_valid <= 1'b1;
                pace_count  <= 5'(2 * pixels_per_byte(setup.color_mode) + 1);
            end else if (pixel_valid) begin
                if (pace_count == '0) begin
                    pixel_valid <= 1'b0;
                    pace_count  <= 5'(LOW_CYCLES - 1);
                end else begin
                    pace_count <= pace_count - 1'b1;
                end
            end else if (pace_count != '0) begin
                pace_count <= pace_count - 1'b1;
            end

            if (sprite_done) begin
                phase <= PHASE_IDLE;  // Drops enable and busy together.
            end
        end
    end

endmodule

// ==== src/sprite_display.sv ====
/*
 * Sprite drawing path. Byte stream in, frame buffer read port out.
 * Frame geometry and queue depth are set here and passed down.
 */

`timescale 1ns/10ps

module sprite_display
    import display_pkg::*;
    import sprite_pkg::*;
#(
    parameter int FRAME_WIDTH     = 640,
    parameter int FRAME_HEIGHT    = 400,
    parameter int BYTE_FIFO_DEPTH = 16
) (
    input  logic           clock_in,
    input  logic           reset,
    input  logic           sprite_start,
    input  logic           byte_valid,
    input  logic [7:0]     byte_data,
    input  logic           sprite_end,
    input  pixel_address_t read_address,
    output color_index_t   read_data,
    output logic           busy,
    output logic           overflow
);

    sprite_setup_t setup;
    logic          enable;
    logic          pixel_valid;
    logic [7:0]    pixel_byte;
    pixel_write_t  pixel_write;

    sprite_command_decoder #(
        .BYTE_FIFO_DEPTH (BYTE_FIFO_DEPTH)
    ) i_decoder (
        .clock_in     (clock_in),
        .reset        (reset),
        .sprite_start (sprite_start),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .sprite_end   (sprite_end),
        .setup        (setup),
        .enable       (enable),
        .pixel_valid  (pixel_valid),
        .pixel_byte   (pixel_byte),
        .busy         (busy),
        .overflow     (overflow)
    );

    sprite_engine #(
        .FRAME_WIDTH (FRAME_WIDTH)
    ) i_engine (
        .clock_in    (clock_in),
        .reset       (reset),
        .enable      (enable),
        .setup       (setup),
        .pixel_valid (pixel_valid),
        .pixel_byte  (pixel_byte),
        .pixel_write (pixel_write)
    );

    frame_buffer #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) i_frame_buffer (
        .clock_in     (clock_in),
        .pixel_write  (pixel_write),
        .read_address (read_address),
        .read_data    (read_data)
    );

endmodule

// ==== src/sprite_engine.sv ====
/*
 * Unpacks pixel bytes into 8, 4 or 2 colour indices, most significant
 * pixel first, and writes them at a pen that wraps after width columns.
 * pixel_valid must stay high until the last pixel of a byte is drawn and
 * go low before the next byte. Width must be at least 1. Each pixel is
 * written on two consecutive cycles. An address past 18 bits is sent as
 * all ones, so the frame buffer drops it.
 */

`timescale 1ns/10ps

module sprite_engine
    import display_pkg::*;
    import sprite_pkg::*;
#(
    parameter int FRAME_WIDTH = 640
) (
    input  logic          clock_in,
    input  logic          reset,
    input  logic          enable,
    input  sprite_setup_t setup,
    input  logic          pixel_valid,
    input  logic [7:0]    pixel_byte,
    output pixel_write_t  pixel_write
);

    localparam int ADDRESS_WIDTH     = $bits(pixel_address_t);
    localparam int ADDRESS_SUM_WIDTH = ADDRESS_WIDTH + 3;

    typedef enum logic [2:0] {
        IDLE,
        NEW_PIXELS,
        DRAW,
        HOLD_OUTPUT,
        WAIT_FOR_NEW_PIXELS
    } engine_state_t;

    engine_state_t                state;
    coordinate_t                  pen_x;
    coordinate_t                  pen_y;
    logic [3:0]                   pixels_remaining;
    logic [2:0]                   pixel_slot;
    logic [10:0]                  last_column;
    logic [ADDRESS_SUM_WIDTH-1:0] linear_address;
    color_index_t                 selected_bits;

    assign pixel_slot  = pixels_remaining[2:0] - 3'd1;  // 8 maps to bit 7.
    assign last_column = 11'(setup.x_position) + 11'(setup.width) - 11'd1;

    assign linear_address = ADDRESS_SUM_WIDTH'(pen_x)
                          + ADDRESS_SUM_WIDTH'(pen_y) * ADDRESS_SUM_WIDTH'(FRAME_WIDTH);

    // ------------------------------
    // Pixel bit selection
    // ------------------------------
    always_comb begin
        case (setup.color_mode)
            COLORS_2: selected_bits = {3'b000, pixel_byte[pixel_slot]};
            COLORS_4: selected_bits = {2'b00, pixel_byte[{pixel_slot[1:0], 1'b0} +: 2]};
            default:  selected_bits = pixel_byte[{pixel_slot[0], 2'b00} +: 4];
        endcase
    end

    // ------------------------------
    // Draw state machine
    // ------------------------------
    always_ff @(posedge clock_in) begin
        if (reset || !enable) begin
            state                    <= IDLE;
            pixel_write.write_enable <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    pen_x <= setup.x_position;
                    pen_y <= setup.y_position;
                    state <= NEW_PIXELS;
                end

                NEW_PIXELS: begin
                    pixels_remaining <= pixels_per_byte(setup.color_mode);
                    if (pixel_valid) begin
                        state <= DRAW;
                    end
                end

                DRAW: begin
                    pixels_remaining <= pixels_remaining - 4'd1;

                    // Pen step with wrap to the next line.
                    if ({1'b0, pen_x} < last_column) begin
                        pen_x <= pen_x + 10'd1;
                    end else begin
                        pen_x <= setup.x_position;
                        pen_y <= pen_y + 10'd1;
                    end

                    if (linear_address[ADDRESS_SUM_WIDTH-1:ADDRESS_WIDTH] != '0) begin
                        pixel_write.address <= '1;
                    end else begin
                        pixel_write.address <= linear_address[ADDRESS_WIDTH-1:0];
                    end

                    pixel_write.color        <= selected_bits + setup.palette_offset;  // Mod 16.
                    pixel_write.write_enable <= 1'b1;
                    state                    <= HOLD_OUTPUT;
                end

                HOLD_OUTPUT: begin
                    if (pixels_remaining == 4'd0) begin
                        state <= WAIT_FOR_NEW_PIXELS;
                    end else begin
                        state <= DRAW;
                    end
                end

                WAIT_FOR_NEW_PIXELS: begin
                    pixel_write.write_enable <= 1'b0;
                    if (!pixel_valid) begin
                        state <= NEW_PIXELS;  // Byte released by the source.
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== src/sprite_pkg.sv ====
/*
 * Sprite setup, colour modes and the host header layout.
 * Mode code 3 is reserved and behaves as 16 colours.
 */

package sprite_pkg;

    import display_pkg::*;

    typedef enum logic [1:0] {
        COLORS_2  = 2'd0,
        COLORS_4  = 2'd1,
        COLORS_16 = 2'd2
    } color_mode_t;

    typedef struct packed {
        coordinate_t  x_position;
        coordinate_t  y_position;
        coordinate_t  width;
        color_mode_t  color_mode;
        color_index_t palette_offset;
        logic [1:0]   spare;
    } sprite_setup_t;

    // Header byte order after sprite_start.
    localparam int HEADER_BYTES  = 7;
    localparam int HEADER_X_HIGH = 0;
    localparam int HEADER_X_LOW  = 1;
    localparam int HEADER_Y_HIGH = 2;
    localparam int HEADER_Y_LOW  = 3;
    localparam int HEADER_W_HIGH = 4;
    localparam int HEADER_W_LOW  = 5;
    localparam int HEADER_MODE   = 6;  // Palette in [7:4], mode in [1:0].

    function automatic logic [3:0] pixels_per_byte(color_mode_t mode);
        case (mode)
            COLORS_2: return 4'd8;
            COLORS_4: return 4'd4;
            default:  return 4'd2;
        endcase
    endfunction

endpackage

// ==== test/clock_gen.sv ====
/*
 * Testbench clock and reset.
 * Reset is high from time zero and drops on the last of RESET_CYCLES
 * rising edges, so it stays synchronous to the clock.
 */

`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clock_in,
    output logic reset
);

    initial begin
        clock_in = 1'b0;
        forever #(PERIOD / 2) clock_in = ~clock_in;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_in);
        reset <= 1'b0;
    end

endmodule

// ==== test/sprite_display_sva.sv ====
/*
 * Concurrent assertions bound into sprite_display.
 * Pixel positions are followed from the write stream itself, which
 * holds each pixel for two cycles and drops write enable between bytes.
 */

`timescale 1ns/10ps

module sprite_display_sva
    import display_pkg::*;
    import sprite_pkg::*;
#(
    parameter int FRAME_WIDTH     = 640,
    parameter int FRAME_HEIGHT    = 400,
    parameter int BYTE_FIFO_DEPTH = 16
) (
    input logic          clock_in,
    input logic          reset,
    input logic          sprite_start,
    input logic          byte_valid,
    input sprite_setup_t setup,
    input logic          enable,
    input logic          pixel_valid,
    input logic          busy,
    input logic          overflow,
    input pixel_write_t  pixel_write
);

    localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;

    int   failure_count = 0;
    logic second_cycle;     // Second of the two cycles of a pixel.
    logic new_pixel;
    logic row_in_frame;
    int   pen_column;
    int   pen_row;
    int   bytes_in_sprite;  // Strobes seen in the pixel phase.

    assign new_pixel    = pixel_write.write_enable && !second_cycle;
    assign row_in_frame = (int'(setup.x_position) + int'(setup.width) <= FRAME_WIDTH)
                          && (int'(setup.y_position) + pen_row < FRAME_HEIGHT);

    // ------------------------------
    // Pen tracking
    // ------------------------------
    always_ff @(posedge clock_in) begin
        if (reset || !enable) begin
            second_cycle <= 1'b0;
            pen_column   <= 0;
            pen_row      <= 0;
        end else begin
            second_cycle <= new_pixel;
            if (new_pixel) begin
                if (pen_column >= int'(setup.width) - 1) begin
                    pen_column <= 0;
                    pen_row    <= pen_row + 1;  // Wrap to the next line.
                end else begin
                    pen_column <= pen_column + 1;
                end
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (reset || sprite_start) begin
            bytes_in_sprite <= 0;
        end else if (enable && byte_valid) begin
            bytes_in_sprite <= bytes_in_sprite + 1;
        end
    end

    // ------------------------------
    // Properties
    // ------------------------------
    assert property (@(posedge clock_in)
        reset |=> !enable && !busy && !pixel_write.write_enable)
        else begin
            failure_count++;
            $error("enable, busy or write enable is high right after reset");
        end

    assert property (@(posedge clock_in) disable iff (reset)
        new_pixel && row_in_frame |-> int'(pixel_write.address) < FRAME_PIXELS)
        else begin
            failure_count++;
            $error("write address beyond the frame for a row inside the frame");
        end

    assert property (@(posedge clock_in) disable iff (reset)
        $rose(pixel_valid) |-> !pixel_write.write_enable)
        else begin
            failure_count++;
            $error("pixel_valid rose while the engine was still drawing");
        end

    assert property (@(posedge clock_in) disable iff (reset)
        $rose(overflow) |-> $past(bytes_in_sprite) >= BYTE_FIFO_DEPTH)
        else begin
            failure_count++;
            $error("overflow set before the byte queue could have filled");
        end

endmodule

bind sprite_display sprite_display_sva #(
    .FRAME_WIDTH     (FRAME_WIDTH),
    .FRAME_HEIGHT    (FRAME_HEIGHT),
    .BYTE_FIFO_DEPTH (BYTE_FIFO_DEPTH)
) i_sva (
    .clock_in     (clock_in),
    .reset        (reset),
    .sprite_start (sprite_start),
    .byte_valid   (byte_valid),
    .setup        (setup),
    .enable       (enable),
    .pixel_valid  (pixel_valid),
    .busy         (busy),
    .overflow     (overflow),
    .pixel_write  (pixel_write)
);

// ==== test/sprite_display_tb.sv ====
/*
 * Testbench for sprite_display. Sprites are streamed in, a model of the
 * frame is built from the placement rule, and each sprite's area plus a
 * one pixel border is read back. The frame starts cleared. The overflow
 * sprite is never read back.
 */

`timescale 1ns/10ps

module sprite_display_tb
    import display_pkg::*;
    import sprite_pkg::*;
();

    localparam int FRAME_WIDTH     = 640;
    localparam int FRAME_HEIGHT    = 400;
    localparam int BYTE_FIFO_DEPTH = 16;

    logic           clock_in;
    logic           reset;
    logic           sprite_start;
    logic           byte_valid;
    logic [7:0]     byte_data;
    logic           sprite_end;
    pixel_address_t read_address;
    color_index_t   read_data;
    logic           busy;
    logic           overflow;

    color_index_t expected_frame [int];  // Only pixels that were drawn.
    logic [7:0]   sprite_bytes [$];
    logic [31:0]  random_state = 32'h68e4_10fd;
    int           test_count   = 0;
    int           check_count  = 0;
    int           test_checks  = 0;
    int           error_count  = 0;
    int           test_errors  = 0;
    int           cycle_count  = 0;
    int           cycle_limit  = 0;

    clock_gen #(.PERIOD(8), .RESET_CYCLES(4)) i_clock_gen (
        .clock_in (clock_in),
        .reset    (reset)
    );

    sprite_display #(
        .FRAME_WIDTH     (FRAME_WIDTH),
        .FRAME_HEIGHT    (FRAME_HEIGHT),
        .BYTE_FIFO_DEPTH (BYTE_FIFO_DEPTH)
    ) i_dut (
        .clock_in     (clock_in),
        .reset        (reset),
        .sprite_start (sprite_start),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .sprite_end   (sprite_end),
        .read_address (read_address),
        .read_data    (read_data),
        .busy         (busy),
        .overflow     (overflow)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(logic [31:0] value);
        logic [31:0] next;
        next = value ^ (value << 13);
        next = next ^ (next >> 17);
        next = next ^ (next << 5);
        return next;
    endfunction

    function automatic int pixel_count(color_mode_t mode);
        if (mode == COLORS_2) return 8;
        if (mode == COLORS_4) return 4;
        return 2;
    endfunction

    // Header, bytes, drain and read-back, in cycles.
    function automatic int sprite_length(int byte_total, color_mode_t mode, int width);
        int rows;
        rows = (byte_total * pixel_count(mode) + width - 1) / width;
        return 20 + 2 * (HEADER_BYTES + byte_total + 2)
               + byte_total * (2 * pixel_count(mode) + 4) + 3 * (width + 2) * (rows + 2);
    endfunction

    task automatic strobe_byte(logic [7:0] value);
        @(posedge clock_in);
        byte_valid <= 1'b1;
        byte_data  <= value;
        @(posedge clock_in);
        byte_valid <= 1'b0;
    endtask

    task automatic start_sprite();
        @(posedge clock_in);
        sprite_start <= 1'b1;
        @(posedge clock_in);
        sprite_start <= 1'b0;
    endtask

    task automatic end_sprite();
        @(posedge clock_in);
        sprite_end <= 1'b1;
        @(posedge clock_in);
        sprite_end <= 1'b0;
    endtask

    task automatic wait_idle();
        do @(posedge clock_in); while (busy);
    endtask

    task automatic send_header(coordinate_t x, coordinate_t y, coordinate_t w,
                               color_mode_t mode, color_index_t palette);
        strobe_byte({6'b0, x[9:8]});
        strobe_byte(x[7:0]);
        strobe_byte({6'b0, y[9:8]});
        strobe_byte(y[7:0]);
        strobe_byte({6'b0, w[9:8]});
        strobe_byte(w[7:0]);
        strobe_byte({palette, 2'b00, mode});
    endtask

    task automatic fill_random_bytes(int count);
        sprite_bytes.delete();
        for (int i = 0; i < count; i++) begin
            random_state = xorshift32(random_state);
            sprite_bytes.push_back(random_state[7:0]);
        end
    endtask

    // Most significant pixel first, pen wraps after w columns.
    task automatic update_model(int x, int y, int w, color_mode_t mode, color_index_t palette);
        int         per_byte;
        int         depth;
        int         column;
        int         row;
        color_index_t bits;
        per_byte = pixel_count(mode);
        depth    = 8 / per_byte;
        column   = 0;
        row      = 0;
        foreach (sprite_bytes[i]) begin
            for (int k = 0; k < per_byte; k++) begin
                bits = 4'((sprite_bytes[i] >> (8 - depth * (k + 1))) & ((1 << depth) - 1));
                if (y + row < FRAME_HEIGHT) begin
                    expected_frame[x + column + (y + row) * FRAME_WIDTH] = bits + palette;
                end
                if (column == w - 1) begin
                    column = 0;
                    row++;
                end else begin
                    column++;
                end
            end
        end
    endtask

    task automatic check_pixel(int address);
        color_index_t expected;
        expected = expected_frame.exists(address) ? expected_frame[address] : 4'h0;
        @(posedge clock_in);
        read_address <= pixel_address_t'(address);
        @(posedge clock_in);
        @(posedge clock_in);  // Registered read port.
        test_checks++;
        assert (read_data == expected) else begin
            $display("ERROR: read_data at address %h expected %h actual %h",
                     address, expected, read_data);
            test_errors++;
        end
    endtask

    task automatic check_area(int x, int y, int w, int rows);
        for (int row = y - 1; row <= y + rows; row++) begin
            for (int column = x - 1; column <= x + w; column++) begin
                if (row >= 0 && row < FRAME_HEIGHT && column >= 0 && column < FRAME_WIDTH) begin
                    check_pixel(column + row * FRAME_WIDTH);
                end
            end
        end
    endtask

    task automatic expect_overflow(logic expected);
        test_checks++;
        assert (overflow === expected) else begin
            $display("ERROR: overflow expected %h actual %h", expected, overflow);
            test_errors++;
        end
    endtask

    task automatic finish_test(string name);
        $display("test %-20s %0d checks, %0d errors", name, test_checks, test_errors);
        test_count++;
        check_count += test_checks;
        error_count += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // Streams sprite_bytes as one sprite, then reads its area back.
    task automatic run_sprite_test(string name, coordinate_t x, coordinate_t y,
                                   coordinate_t w, color_mode_t mode, color_index_t palette);
        int rows;
        rows = (sprite_bytes.size() * pixel_count(mode) + int'(w) - 1) / int'(w);
        start_sprite();
        send_header(x, y, w, mode, palette);
        foreach (sprite_bytes[i]) begin
            strobe_byte(sprite_bytes[i]);
        end
        end_sprite();
        wait_idle();
        update_model(int'(x), int'(y), int'(w), mode, palette);
        check_area(int'(x), int'(y), int'(w), rows);
        finish_test(name);
    endtask

    // 24 back-to-back strobes into the 16-entry queue.
    task automatic run_overflow_test();
        start_sprite();
        send_header(10'd0, 10'd300, 10'd40, COLORS_16, 4'h0);
        for (int i = 0; i < 24; i++) begin
            random_state = xorshift32(random_state);
            @(posedge clock_in);
            byte_valid <= 1'b1;
            byte_data  <= random_state[7:0];
        end
        @(posedge clock_in);
        byte_valid <= 1'b0;
        @(posedge clock_in);
        expect_overflow(1'b1);
        end_sprite();
        wait_idle();
        expect_overflow(1'b1);  // Held through the end of the sprite.
        start_sprite();
        @(posedge clock_in);
        expect_overflow(1'b0);
        send_header(10'd0, 10'd350, 10'd4, COLORS_2, 4'h0);
        end_sprite();
        wait_idle();
        finish_test("overflow");
    endtask

    // ------------------------------
    // Run limit
    // ------------------------------
    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        sprite_start = 1'b0;
        byte_valid   = 1'b0;
        byte_data    = 8'h00;
        sprite_end   = 1'b0;
        read_address = '0;
        cycle_limit  = 200 + 2 * (sprite_length(2, COLORS_2, 16) + sprite_length(3, COLORS_4, 3)
                       + sprite_length(4, COLORS_16, 5) + sprite_length(3, COLORS_2, 8)
                       + sprite_length(24, COLORS_16, 40) + sprite_length(0, COLORS_2, 4));

        @(posedge clock_in);
        while (reset) @(posedge clock_in);

        fill_random_bytes(2);
        run_sprite_test("two_colors", 10'd3, 10'd5, 10'd16, COLORS_2, 4'h4);

        fill_random_bytes(3);
        run_sprite_test("four_colors_wrap", 10'd100, 10'd20, 10'd3, COLORS_4, 4'h0);

        sprite_bytes = '{8'h0f, 8'h37, 8'ha5, 8'hc9};  // Nibbles both below and above 4.
        run_sprite_test("sixteen_colors", 10'd200, 10'd50, 10'd5, COLORS_16, 4'hc);

        fill_random_bytes(3);
        run_sprite_test("frame_edge", 10'd600, 10'd398, 10'd8, COLORS_2, 4'h1);

        run_overflow_test();

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_count, check_count, error_count, i_dut.i_sva.failure_count);
        if (error_count == 0 && i_dut.i_sva.failure_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
